// File: hdl/ifu_cfg.svh
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// datapath
`define IFU_XLEN 32

// predictor sizing
`define IFU_HISLEN 8       // gshare has 2^HISLEN counters
`define IFU_BTB_ENTRIES 16
`define IFU_RAS_DEPTH 4

// fetch trap bus, cause numbers from the privileged spec
`define IFU_TRAP_LEN 16
`define IFU_TRAP_INST_ADDR_MISALIGNED 0
`define IFU_TRAP_INST_ACCESS_FAULT 1
`define IFU_TRAP_INST_PAGE_FAULT 12

`endif

// File: hdl/rv_isa_pkg.sv
`include "ifu_cfg.svh"

package rv_isa_pkg;

  typedef logic [`IFU_XLEN-1:0] xlen_t;
  typedef logic [31:0] inst_t;              // base encoding only, no rvc
  typedef logic [`IFU_TRAP_LEN-1:0] trap_bus_t;

  // encoding shared with the execute stage
  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

endpackage

// File: hdl/bpu_pkg.sv
`include "ifu_cfg.svh"

package bpu_pkg;

  typedef logic [`IFU_HISLEN-1:0] history_t;
  typedef logic [1:0] pht_cnt_t;
  typedef logic [`IFU_HISLEN-1:0] pht_idx_t;
  typedef logic [$clog2(`IFU_BTB_ENTRIES)-1:0] btb_idx_t;
  typedef logic [$clog2(`IFU_RAS_DEPTH)-1:0] ras_ptr_t;

  localparam pht_cnt_t PHT_CNT_INIT = 2'b01;  // weakly not taken

  // where the predicted target comes from
  typedef enum logic [2:0] {
    SRC_NONE,
    SRC_JAL,
    SRC_BRANCH,
    SRC_RAS,
    SRC_BTB
  } pdt_src_e;

endpackage

// File: hdl/gshare_table.sv
`timescale 1ns/1ps

module gshare_table
  import bpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  pht_idx_t rd_idx_i,
  output pht_cnt_t rd_cnt_o,
  input  logic     upd_valid_i,
  input  pht_idx_t upd_idx_i,
  input  logic     upd_taken_i
);

  localparam int ENTRIES = 2 ** $bits(pht_idx_t);

  pht_cnt_t pht [ENTRIES];
  pht_cnt_t upd_old;
  pht_cnt_t upd_new;

  assign rd_cnt_o = pht[rd_idx_i];  // same cycle as the fetch
  assign upd_old  = pht[upd_idx_i];

  // move one step toward the resolved direction, stick at the ends
  always_comb begin
    upd_new = upd_old;
    if (upd_taken_i && (upd_old != 2'b11)) begin
      upd_new = upd_old + 2'd1;
    end else if (!upd_taken_i && (upd_old != 2'b00)) begin
      upd_new = upd_old - 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ENTRIES; i++) begin
        pht[i] <= PHT_CNT_INIT;
      end
    end else if (upd_valid_i) begin
      pht[upd_idx_i] <= upd_new;
    end
  end

  // no wrap between 00 and 11
  a_one_step : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    upd_valid_i |=>
      ((int'(pht[$past(upd_idx_i)]) - int'($past(upd_old))) inside {-1, 0, 1})
  );

endmodule

// File: hdl/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer
  import rv_isa_pkg::*;
  import bpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  xlen_t lookup_pc_i,
  output logic  hit_o,
  output xlen_t target_o,
  input  logic  wr_valid_i,
  input  xlen_t wr_pc_i,
  input  xlen_t wr_target_i
);

  localparam int IDX_W   = $bits(btb_idx_t);
  localparam int TAG_W   = $bits(xlen_t) - IDX_W - 2;  // pc[1:0] never indexes
  localparam int ENTRIES = 2 ** IDX_W;

  typedef logic [TAG_W-1:0] btb_tag_t;

  logic     vld [ENTRIES];
  btb_tag_t tag [ENTRIES];
  xlen_t    tgt [ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;

  assign rd_idx = lookup_pc_i[IDX_W+1:2];
  assign rd_tag = lookup_pc_i[$bits(xlen_t)-1:IDX_W+2];
  assign wr_idx = wr_pc_i[IDX_W+1:2];
  assign wr_tag = wr_pc_i[$bits(xlen_t)-1:IDX_W+2];

  // direct mapped, so one compare
  assign hit_o    = vld[rd_idx] && (tag[rd_idx] == rd_tag);
  assign target_o = tgt[rd_idx];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ENTRIES; i++) begin
        vld[i] <= 1'b0;
      end
    end else if (wr_valid_i) begin
      vld[wr_idx] <= 1'b1;
    end
  end

  // a new jalr at the same index simply evicts the old one
  always_ff @(posedge clk) begin
    if (wr_valid_i) begin
      tag[wr_idx] <= wr_tag;
      tgt[wr_idx] <= wr_target_i;
    end
  end

endmodule

// File: hdl/return_addr_stack.sv
`timescale 1ns/1ps

module return_addr_stack
  import rv_isa_pkg::*;
  import bpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  xlen_t push_addr_i,
  input  logic  pop_i,
  output xlen_t top_o,
  output logic  valid_o
);

  localparam int DEPTH = 2 ** $bits(ras_ptr_t);

  typedef logic [$bits(ras_ptr_t):0] ras_cnt_t;

  xlen_t    stack [DEPTH];
  ras_ptr_t wr_ptr;   // next free slot, wraps onto the oldest
  ras_ptr_t top_ptr;
  ras_cnt_t count;
  logic     pop_vld;

  assign top_ptr = wr_ptr - 1'b1;
  assign valid_o = (count != '0);
  assign top_o   = stack[top_ptr];
  assign pop_vld = pop_i && valid_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i && !pop_vld) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (count != ras_cnt_t'(DEPTH)) begin
          count <= count + 1'b1;
        end
      end else if (pop_vld && !push_i) begin
        wr_ptr <= top_ptr;
        count  <= count - 1'b1;
      end
    end
  end

  // push with pop swaps the top in place
  always_ff @(posedge clk) begin
    if (push_i) begin
      stack[pop_vld ? top_ptr : wr_ptr] <= push_addr_i;
    end
  end

  a_cnt_bound : assert property (
    @(posedge clk) disable iff (!rst_n_i) count <= ras_cnt_t'(DEPTH)
  );

endmodule

// File: hdl/fetch_ctrl.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module fetch_ctrl
  import rv_isa_pkg::*;
  import bpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  xlen_t      inst_addr_i,
  input  logic       if_rdata_valid_i,
  input  xlen_t      if_rdata_i,
  input  logic       ex_branch_valid_i,
  input  logic       ex_branch_taken_i,
  input  logic       ex_pdt_true_i,
  input  xlen_t      ex_pc_i,
  input  history_t   ex_history_i,
  input  jump_type_e ex_jump_type_i,
  input  logic       if_flush_i,
  input  logic       id_stall_i,
  // predictor tables
  output pht_idx_t   pht_idx_o,
  input  pht_cnt_t   pht_cnt_i,
  output logic       pht_upd_valid_o,
  output pht_idx_t   pht_upd_idx_o,
  output xlen_t      btb_pc_o,
  input  logic       btb_hit_i,
  input  xlen_t      btb_target_i,
  output logic       btb_wr_valid_o,
  output logic       ras_pop_o,
  input  xlen_t      ras_top_i,
  input  logic       ras_valid_i,
  // pipeline side
  output logic       ram_stall_valid_if_o,
  output xlen_t      inst_addr_o,
  output inst_t      inst_data_o,
  output trap_bus_t  trap_bus_o,
  output xlen_t      bpu_pc_o,
  output logic       bpu_pc_valid_o,
  output logic       pdt_res_o,
  output history_t   history_o
);

  inst_t      inst;
  opcode_e    opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  xlen_t      imm_b;
  xlen_t      imm_j;
  logic       misaligned;
  logic       pdt_en;
  logic       is_branch;
  logic       is_ret;
  logic       ex_is_branch;
  logic       ex_mispdt;
  pdt_src_e   src;
  history_t   spec_hist;

  // pre-decode
  assign inst   = if_rdata_i;
  assign opcode = opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign misaligned = |inst_addr_i[1:0];
  assign pdt_en     = if_rdata_valid_i && !if_flush_i && !id_stall_i && !misaligned;
  assign is_branch  = (opcode == OPC_BRANCH);
  // jalr x0, 0(ra) or 0(t0)
  assign is_ret     = (opcode == OPC_JALR) && (rd == 5'd0) && ((rs1 == 5'd1) || (rs1 == 5'd5));

  assign pht_idx_o = inst_addr_i[`IFU_HISLEN+1:2] ^ spec_hist;
  assign btb_pc_o  = inst_addr_i;

  always_comb begin
    src = SRC_NONE;
    if (pdt_en) begin
      case (opcode)
        OPC_JAL: src = SRC_JAL;  // always taken
        OPC_BRANCH: begin
          if (pht_cnt_i[1]) begin
            src = SRC_BRANCH;
          end
        end
        OPC_JALR: begin
          if (is_ret && ras_valid_i) begin
            src = SRC_RAS;
          end else if (!is_ret && btb_hit_i) begin
            src = SRC_BTB;
          end
        end
        default: src = SRC_NONE;
      endcase
    end
  end

  always_comb begin
    case (src)
      SRC_JAL:    bpu_pc_o = inst_addr_i + imm_j;
      SRC_BRANCH: bpu_pc_o = inst_addr_i + imm_b;
      SRC_RAS:    bpu_pc_o = ras_top_i;
      SRC_BTB:    bpu_pc_o = btb_target_i;
      default:    bpu_pc_o = inst_addr_i + xlen_t'(4);  // sequential
    endcase
  end

  assign bpu_pc_valid_o = (src != SRC_NONE);
  assign pdt_res_o      = is_branch ? pht_cnt_i[1] : bpu_pc_valid_o;
  assign ras_pop_o      = (src == SRC_RAS);

  // training from execute
  assign ex_is_branch    = ex_branch_valid_i && (ex_jump_type_i == JT_BRANCH);
  assign ex_mispdt       = ex_is_branch && !ex_pdt_true_i;
  assign pht_upd_valid_o = ex_is_branch;
  assign pht_upd_idx_o   = ex_pc_i[`IFU_HISLEN+1:2] ^ ex_history_i;
  assign btb_wr_valid_o  = ex_branch_valid_i && (ex_jump_type_i == JT_JALR);

  // repair wins over the speculative shift
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      spec_hist <= '0;
    end else if (ex_mispdt) begin
      spec_hist <= {ex_history_i[`IFU_HISLEN-2:0], ex_branch_taken_i};
    end else if (pdt_en && is_branch) begin
      spec_hist <= {spec_hist[`IFU_HISLEN-2:0], pdt_res_o};
    end
  end

  assign history_o = spec_hist;

  assign inst_addr_o          = inst_addr_i;
  assign inst_data_o          = inst;
  assign ram_stall_valid_if_o = !if_rdata_valid_i;  // hold pipe until imem answers

  always_comb begin
    trap_bus_o = '0;
    trap_bus_o[`IFU_TRAP_INST_ADDR_MISALIGNED] = misaligned;
    trap_bus_o[`IFU_TRAP_INST_ACCESS_FAULT]    = 1'b0;  // no pmp here
    trap_bus_o[`IFU_TRAP_INST_PAGE_FAULT]      = 1'b0;  // no mmu either
  end

  // stack must not underflow through a predicted return
  a_pop_nonempty : assert property (
    @(posedge clk) disable iff (!rst_n_i) $rose(ras_pop_o) |-> ras_valid_i
  );

endmodule

// File: hdl/ifu.sv
`timescale 1ns/1ps

module ifu
  import rv_isa_pkg::*;
  import bpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  xlen_t      inst_addr_i,
  input  logic       if_rdata_valid_i,
  input  xlen_t      if_rdata_i,
  input  logic       ex_branch_valid_i,
  input  logic       ex_branch_taken_i,
  input  logic       ex_pdt_true_i,
  input  xlen_t      ex_pc_i,
  input  history_t   ex_history_i,
  input  jump_type_e ex_jump_type_i,
  input  xlen_t      ex_target_i,
  input  logic       id_ras_push_valid_i,
  input  xlen_t      id_ras_push_data_i,
  input  logic       if_flush_i,
  input  logic       id_stall_i,
  output logic       ram_stall_valid_if_o,
  output xlen_t      inst_addr_o,
  output inst_t      inst_data_o,
  output trap_bus_t  trap_bus_o,
  output xlen_t      bpu_pc_o,
  output logic       bpu_pc_valid_o,
  output logic       pdt_res_o,
  output history_t   history_o
);

  pht_idx_t pht_idx;
  pht_cnt_t pht_cnt;
  logic     pht_upd_valid;
  pht_idx_t pht_upd_idx;
  xlen_t    btb_pc;
  logic     btb_hit;
  xlen_t    btb_target;
  logic     btb_wr_valid;
  logic     ras_pop;
  xlen_t    ras_top;
  logic     ras_valid;

  fetch_ctrl fetch_ctrl_i (
    .clk                  (clk),
    .rst_n_i              (rst_n_i),
    .inst_addr_i          (inst_addr_i),
    .if_rdata_valid_i     (if_rdata_valid_i),
    .if_rdata_i           (if_rdata_i),
    .ex_branch_valid_i    (ex_branch_valid_i),
    .ex_branch_taken_i    (ex_branch_taken_i),
    .ex_pdt_true_i        (ex_pdt_true_i),
    .ex_pc_i              (ex_pc_i),
    .ex_history_i         (ex_history_i),
    .ex_jump_type_i       (ex_jump_type_i),
    .if_flush_i           (if_flush_i),
    .id_stall_i           (id_stall_i),
    .pht_idx_o            (pht_idx),
    .pht_cnt_i            (pht_cnt),
    .pht_upd_valid_o      (pht_upd_valid),
    .pht_upd_idx_o        (pht_upd_idx),
    .btb_pc_o             (btb_pc),
    .btb_hit_i            (btb_hit),
    .btb_target_i         (btb_target),
    .btb_wr_valid_o       (btb_wr_valid),
    .ras_pop_o            (ras_pop),
    .ras_top_i            (ras_top),
    .ras_valid_i          (ras_valid),
    .ram_stall_valid_if_o (ram_stall_valid_if_o),
    .inst_addr_o          (inst_addr_o),
    .inst_data_o          (inst_data_o),
    .trap_bus_o           (trap_bus_o),
    .bpu_pc_o             (bpu_pc_o),
    .bpu_pc_valid_o       (bpu_pc_valid_o),
    .pdt_res_o            (pdt_res_o),
    .history_o            (history_o)
  );

  gshare_table gshare_table_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rd_idx_i    (pht_idx),
    .rd_cnt_o    (pht_cnt),
    .upd_valid_i (pht_upd_valid),
    .upd_idx_i   (pht_upd_idx),
    .upd_taken_i (ex_branch_taken_i)
  );

  branch_target_buffer branch_target_buffer_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (btb_pc),
    .hit_o       (btb_hit),
    .target_o    (btb_target),
    .wr_valid_i  (btb_wr_valid),
    .wr_pc_i     (ex_pc_i),
    .wr_target_i (ex_target_i)
  );

  // calls are pushed from decode
  return_addr_stack return_addr_stack_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .push_i      (id_ras_push_valid_i),
    .push_addr_i (id_ras_push_data_i),
    .pop_i       (ras_pop),
    .top_o       (ras_top),
    .valid_o     (ras_valid)
  );

endmodule

// File: verification/tb_ifu.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module tb_ifu
  import rv_isa_pkg::*;
  import bpu_pkg::*;
();

  localparam inst_t NOP = 32'h0000_0013;  // addi x0, x0, 0
  localparam int    PHT_N = 2 ** `IFU_HISLEN;

  logic       clk;
  logic       rst_n_i;
  xlen_t      inst_addr_i;
  logic       if_rdata_valid_i;
  xlen_t      if_rdata_i;
  logic       ex_branch_valid_i;
  logic       ex_branch_taken_i;
  logic       ex_pdt_true_i;
  xlen_t      ex_pc_i;
  history_t   ex_history_i;
  jump_type_e ex_jump_type_i;
  xlen_t      ex_target_i;
  logic       id_ras_push_valid_i;
  xlen_t      id_ras_push_data_i;
  logic       if_flush_i;
  logic       id_stall_i;
  logic       ram_stall_valid_if_o;
  xlen_t      inst_addr_o;
  inst_t      inst_data_o;
  trap_bus_t  trap_bus_o;
  xlen_t      bpu_pc_o;
  logic       bpu_pc_valid_o;
  logic       pdt_res_o;
  history_t   history_o;

  integer   seed;
  pht_cnt_t pht_m [PHT_N];  // reference counters
  history_t hist_m;
  xlen_t    btb_pc_m [int];
  xlen_t    btb_tgt_m [int];
  xlen_t    ras_q [$];      // back is top of stack

  ifu ifu_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_history(input string name, input history_t exp, input history_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_trap(input string name, input trap_bus_t exp, input trap_bus_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // RV32I encodings, immediates given with bit 0 clear
  function automatic inst_t enc_jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic inst_t enc_branch(input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, rd, OPC_JALR};
  endfunction

  function automatic pht_cnt_t sat_step(input pht_cnt_t cnt, input logic taken);
    if (taken) begin
      return (cnt == 2'b11) ? cnt : cnt + 2'd1;
    end
    return (cnt == 2'b00) ? cnt : cnt - 2'd1;
  endfunction

  function automatic logic cnt_hi(input xlen_t pc);
    return pht_m[pc[`IFU_HISLEN+1:2] ^ hist_m][1];
  endfunction

  function automatic logic btb_hits(input xlen_t pc);
    int k;
    k = int'(pc[5:2]);
    return btb_pc_m.exists(k) && (btb_pc_m[k][31:6] == pc[31:6]);
  endfunction

  // next edge plus 2 ns, strobes back to idle
  task automatic tick();
    @(posedge clk);
    #2;
    inst_addr_i         = 32'h0000_1000;
    if_rdata_i          = NOP;
    if_rdata_valid_i    = 1'b1;
    if_flush_i          = 1'b0;
    id_stall_i          = 1'b0;
    ex_branch_valid_i   = 1'b0;
    id_ras_push_valid_i = 1'b0;
  endtask

  task automatic present_fetch(input string name, input xlen_t pc, input inst_t inst,
                               input logic flush, input logic stall, input logic exp_vld,
                               input xlen_t exp_tgt, input logic exp_res);
    tick();
    inst_addr_i = pc;
    if_rdata_i  = inst;
    if_flush_i  = flush;
    id_stall_i  = stall;
    #1;
    check_history(name, hist_m, history_o);
    check_bit(name, exp_vld, bpu_pc_valid_o);
    check_bit(name, exp_res, pdt_res_o);
    if (exp_vld) begin
      check_xlen(name, exp_tgt, bpu_pc_o);
    end
  endtask

  task automatic ex_update(input jump_type_e jt, input xlen_t pc, input history_t h,
                           input logic taken, input logic pdt_true, input xlen_t tgt);
    pht_idx_t idx;
    idx = pc[`IFU_HISLEN+1:2] ^ h;
    tick();
    ex_branch_valid_i = 1'b1;
    ex_jump_type_i    = jt;
    ex_pc_i           = pc;
    ex_history_i      = h;
    ex_branch_taken_i = taken;
    ex_pdt_true_i     = pdt_true;
    ex_target_i       = tgt;
    if (jt == JT_BRANCH) begin
      pht_m[idx] = sat_step(pht_m[idx], taken);
      if (!pdt_true) begin
        hist_m = {h[`IFU_HISLEN-2:0], taken};  // repair
      end
    end else if (jt == JT_JALR) begin
      btb_pc_m[int'(pc[5:2])]  = pc;
      btb_tgt_m[int'(pc[5:2])] = tgt;
    end
  endtask

  task automatic push_ras(input xlen_t addr);
    tick();
    id_ras_push_valid_i = 1'b1;
    id_ras_push_data_i  = addr;
    ras_q.push_back(addr);
    if (ras_q.size() > `IFU_RAS_DEPTH) begin
      ras_q.delete(0);  // oldest overwritten
    end
  endtask

  task automatic wait_stall_low(input string name);
    int n;
    n = 0;
    tick();
    #1;
    while (ram_stall_valid_if_o !== 1'b0) begin
      if (n == 16) begin
        $display("%s: stall request never dropped with valid fetch data", name);
        stop_run();
      end
      n++;
      tick();
      #1;
    end
  endtask

  task automatic test_passthrough();
    xlen_t pc;
    xlen_t w;
    logic  vld;
    for (int i = 0; i < 8; i++) begin
      tick();
      pc    = xlen_t'($random(seed)) & ~xlen_t'(3);
      w     = xlen_t'($random(seed));
      w[6:0] = 7'b0110011;  // plain alu op
      vld   = 1'($random(seed));
      inst_addr_i      = pc;
      if_rdata_i       = w;
      if_rdata_valid_i = vld;
      #1;
      check_xlen("passthrough_addr", pc, inst_addr_o);
      check_xlen("passthrough_data", w, inst_data_o);
      check_bit("passthrough_stall", !vld, ram_stall_valid_if_o);
      check_bit("passthrough_pred", 1'b0, bpu_pc_valid_o);
      check_trap("passthrough_trap", '0, trap_bus_o);
    end
    wait_stall_low("passthrough_resume");
  endtask

  task automatic test_jal();
    xlen_t        pc;
    logic [20:0]  imm;
    for (int i = 0; i < 4; i++) begin
      pc  = xlen_t'($random(seed)) & ~xlen_t'(3);
      imm = 21'($random(seed)) & 21'h1ffffe;
      present_fetch("jal", pc, enc_jal(5'd1, imm), 1'b0, 1'b0, 1'b1,
                    pc + {{11{imm[20]}}, imm}, 1'b1);
    end
  endtask

  task automatic test_gshare();
    xlen_t       pc;
    logic [12:0] imm;
    xlen_t       tgt;
    history_t    h;
    logic        res;
    pc  = xlen_t'($random(seed)) & ~xlen_t'(3);
    imm = 13'($random(seed)) & 13'h1ffe;
    tgt = pc + {{19{imm[12]}}, imm};
    res = cnt_hi(pc);  // 01 after reset
    present_fetch("gshare_cold", pc, enc_branch(imm), 1'b0, 1'b0, res, tgt, res);
    hist_m = {hist_m[`IFU_HISLEN-2:0], res};
    tick();
    #1;
    check_history("gshare_observe", hist_m, history_o);
    h = history_o;
    ex_update(JT_BRANCH, pc, h, 1'b1, 1'b1, '0);
    ex_update(JT_BRANCH, pc, h, 1'b1, 1'b1, '0);
    res = cnt_hi(pc);
    present_fetch("gshare_trained", pc, enc_branch(imm), 1'b0, 1'b0, res, tgt, res);
    hist_m = {hist_m[`IFU_HISLEN-2:0], res};
    // mispredict in the same cycle as a new branch fetch
    tick();
    res = cnt_hi(pc);
    inst_addr_i       = pc;
    if_rdata_i        = enc_branch(imm);
    ex_branch_valid_i = 1'b1;
    ex_jump_type_i    = JT_BRANCH;
    ex_pc_i           = pc;
    ex_history_i      = 8'h5a;
    ex_branch_taken_i = 1'b0;
    ex_pdt_true_i     = 1'b0;
    #1;
    check_bit("gshare_mispredict", res, bpu_pc_valid_o);
    check_history("gshare_mispredict", hist_m, history_o);
    pht_m[pc[`IFU_HISLEN+1:2] ^ 8'h5a] = sat_step(pht_m[pc[`IFU_HISLEN+1:2] ^ 8'h5a], 1'b0);
    hist_m = {7'h5a, 1'b0};
    present_fetch("gshare_repair", 32'h0000_2000, NOP, 1'b0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic test_ras();
    xlen_t pc;
    xlen_t exp;
    pc = xlen_t'($random(seed)) & ~xlen_t'(3);
    for (int i = 0; i < 5; i++) begin
      push_ras(xlen_t'($random(seed)) & ~xlen_t'(3));
    end
    for (int i = 0; i < 4; i++) begin
      exp = ras_q[$];
      present_fetch("ras_pop", pc, enc_jalr(5'd0, (i % 2) ? 5'd5 : 5'd1), 1'b0, 1'b0,
                    1'b1, exp, 1'b1);
      ras_q.delete(ras_q.size() - 1);
    end
    present_fetch("ras_empty", pc, enc_jalr(5'd0, 5'd1), 1'b0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic test_btb();
    xlen_t pc;
    xlen_t tgt;
    inst_t ji;
    pc  = xlen_t'($random(seed)) & ~xlen_t'(3);
    tgt = xlen_t'($random(seed)) & ~xlen_t'(3);
    ji  = enc_jalr(5'd1, 5'd6);  // indirect call, not a return
    present_fetch("btb_cold", pc, ji, 1'b0, 1'b0, btb_hits(pc), '0, btb_hits(pc));
    ex_update(JT_JALR, pc, '0, 1'b1, 1'b1, tgt);
    present_fetch("btb_hit", pc, ji, 1'b0, 1'b0, btb_hits(pc), btb_tgt_m[int'(pc[5:2])],
                  btb_hits(pc));
    pc = pc ^ 32'h0000_0400;  // same index, new tag
    present_fetch("btb_alias", pc, ji, 1'b0, 1'b0, btb_hits(pc), '0, btb_hits(pc));
  endtask

  task automatic test_suppress();
    xlen_t pc;
    xlen_t ra;
    pc = xlen_t'($random(seed)) & ~xlen_t'(3);
    ra = xlen_t'($random(seed)) & ~xlen_t'(3);
    present_fetch("misaligned", pc | 32'h2, enc_jal(5'd1, 21'h000100), 1'b0, 1'b0,
                  1'b0, '0, 1'b0);
    check_trap("misaligned", trap_bus_t'(1) << `IFU_TRAP_INST_ADDR_MISALIGNED, trap_bus_o);
    push_ras(ra);
    present_fetch("flush_ret", pc, enc_jalr(5'd0, 5'd1), 1'b1, 1'b0, 1'b0, '0, 1'b0);
    present_fetch("stall_ret", pc, enc_jalr(5'd0, 5'd1), 1'b0, 1'b1, 1'b0, '0, 1'b0);
    present_fetch("flush_branch", pc, enc_branch(13'h0040), 1'b1, 1'b0, 1'b0, '0, cnt_hi(pc));
    present_fetch("stall_branch", pc, enc_branch(13'h0040), 1'b0, 1'b1, 1'b0, '0, cnt_hi(pc));
    // stack still holds ra, history unshifted
    present_fetch("ret_after_kill", pc, enc_jalr(5'd0, 5'd1), 1'b0, 1'b0, 1'b1, ras_q[$], 1'b1);
    ras_q.delete(ras_q.size() - 1);
    present_fetch("suppress_end", pc, NOP, 1'b0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  initial begin
    #200000;
    $display("timeout: the run did not finish in time");
    stop_run();
  end

  initial begin
    seed                = 32'hd8b6;
    rst_n_i             = 1'b0;
    inst_addr_i         = '0;
    if_rdata_valid_i    = 1'b0;
    if_rdata_i          = NOP;
    ex_branch_valid_i   = 1'b0;
    ex_branch_taken_i   = 1'b0;
    ex_pdt_true_i       = 1'b0;
    ex_pc_i             = '0;
    ex_history_i        = '0;
    ex_jump_type_i      = JT_NONE;
    ex_target_i         = '0;
    id_ras_push_valid_i = 1'b0;
    id_ras_push_data_i  = '0;
    if_flush_i          = 1'b0;
    id_stall_i          = 1'b0;
    hist_m              = '0;
    for (int i = 0; i < PHT_N; i++) begin
      pht_m[i] = 2'b01;
    end
    repeat (2) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    test_passthrough();
    test_jal();
    test_gshare();
    test_ras();
    test_btb();
    test_suppress();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/bpu_pkg.sv
hdl/gshare_table.sv
hdl/branch_target_buffer.sv
hdl/return_addr_stack.sv
hdl/fetch_ctrl.sv
hdl/ifu.sv
verification/tb_ifu.sv

// File: Bender.yml
package:
  name: ifu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/bpu_pkg.sv
      - hdl/gshare_table.sv
      - hdl/branch_target_buffer.sv
      - hdl/return_addr_stack.sv
      - hdl/fetch_ctrl.sv
      - hdl/ifu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_ifu.sv
